//--- Bender.yml
package:
  name: mandel_tile

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mandel_pkg.sv
      - verilog/tile_control.sv
      - verilog/escape_iterator.sv
      - verilog/palette_map.sv
      - verilog/hex_display.sv
      - verilog/mandel_tile_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/mandel_tile_properties.sv
      - tb/mandel_tile_tb.sv

//--- tb/mandel_tile_properties.sv
`timescale 1ns/100ps
`include "mandel_defs.svh"

module mandel_tile_properties (
	input logic                   CLOCK_50,
	input logic                   reset_key,
	input logic                   start,
	input mandel_pkg::write_rec_t wr,
	input logic                   wr_valid,
	input logic                   done
);
	import mandel_pkg::*;

	logic active;
	logic seen;
	logic [2*`MANDEL_TILE_BITS-1:0] prev_addr;
	int fail_count = 0;

	//////////////////////////////
	// tile tracking
	//////////////////////////////

	// active through the done cycle
	// a start in that cycle reopens
	always_ff @(posedge CLOCK_50) begin
		if (reset_key) begin
			active <= 1'b0;
			seen <= 1'b0;
		end else begin
			if (done)
				active <= start;
			else if (start)
				active <= 1'b1;
			// first write of a tile must be 0
			if (done)
				seen <= 1'b0;
			else if (wr_valid)
				seen <= 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (wr_valid)
			prev_addr <= wr.addr;
	end

	done_single: assert property (@(posedge CLOCK_50) disable iff (reset_key)
		done |=> !done)
		else begin
			$error("done held longer than one cycle");
			fail_count++;
		end

	no_idle_write: assert property (@(posedge CLOCK_50) disable iff (reset_key)
		!active |-> !wr_valid)
		else begin
			$error("write strobe while no tile is running");
			fail_count++;
		end

	addr_first: assert property (@(posedge CLOCK_50) disable iff (reset_key)
		(wr_valid && !seen) |-> (wr.addr == '0))
		else begin
			$error("first write of a tile not at address 0");
			fail_count++;
		end

	addr_step: assert property (@(posedge CLOCK_50) disable iff (reset_key)
		(wr_valid && seen) |-> (wr.addr == prev_addr + 1'b1))
		else begin
			$error("write address did not step by one");
			fail_count++;
		end

	done_on_last: assert property (@(posedge CLOCK_50) disable iff (reset_key)
		done |-> (wr_valid && (&wr.addr)))
		else begin
			$error("done without the write to the last address");
			fail_count++;
		end

endmodule

bind mandel_tile_top mandel_tile_properties i_mandel_tile_properties (
	.CLOCK_50  (CLOCK_50),
	.reset_key (reset_key),
	.start     (start),
	.wr        (wr),
	.wr_valid  (wr_valid),
	.done      (done)
);

//--- tb/mandel_tile_tb.sv
`timescale 1ns/100ps
`include "mandel_defs.svh"

module mandel_tile_tb;
	import mandel_pkg::*;

	localparam int tile_pixels = 1 << (2 * `MANDEL_TILE_BITS);
	// interior 1, random 2, display 1, restart 2
	localparam int tile_count = 6;
	localparam int max_limit = 100;
	// worst case per pixel is limit + 3 edges
	localparam int timeout_cycles = tile_count * tile_pixels * (max_limit + 3) + 5000;

	logic CLOCK_50 = 1'b0;
	logic reset_key;
	tile_cfg_t cfg;
	logic start;
	write_rec_t wr;
	logic wr_valid;
	logic done;
	logic [31:0] solve_time;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [7:0] ledr;
	logic [41:0] hex_all;
	int seed = 97428;
	int cycle_count = 0;
	int last_elapsed = 0;

	mandel_tile_top i_mandel_tile_top (
		.CLOCK_50   (CLOCK_50),
		.reset_key  (reset_key),
		.cfg        (cfg),
		.start      (start),
		.wr         (wr),
		.wr_valid   (wr_valid),
		.done       (done),
		.solve_time (solve_time),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5),
		.ledr       (ledr)
	);

	// digits side by side with hex0 at the bottom
	assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

	// 40 ns period
	always #20 CLOCK_50 = ~CLOCK_50;

	// hard stop on a stuck tile
	always @(posedge CLOCK_50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// keep low word bits and sign extend back
	function automatic longint wrap_word(input longint v);
		fixed_t t;
		t = v[`MANDEL_WORD_BITS-1:0];
		return longint'(t);
	endfunction

	// RGB565 with red always 0
	function automatic logic [15:0] ramp_color(input int level);
		logic [5:0] g;
		logic [4:0] b;
		if (level <= 6) begin
			g = 6'(8 * level);
			b = 5'd0;
		end else if (level == 7) begin
			g = 6'd56;
			b = 5'd8;
		end else if (level == 8) begin
			g = 6'd56;
			b = 5'd16;
		end else begin
			g = 6'(8 * (15 - level));
			b = 5'd24;
		end
		return {5'd0, g, b};
	endfunction

	// colour one pixel straight from the iteration rule
	function automatic logic [15:0] expect_color(input tile_cfg_t c, input int idx);
		longint cr;
		longint ci;
		longint zr;
		longint zi;
		longint zr2;
		longint zi2;
		longint zrzi;
		int count;
		cr = wrap_word(longint'(c.x_min) + (idx % 32) * longint'(c.dx));
		ci = wrap_word(longint'(c.y_min) + (idx / 32) * longint'(c.dy));
		zr = 0;
		zi = 0;
		for (count = 0; count <= int'(c.iter_limit); count++) begin
			zr2 = zr * zr;
			zi2 = zi * zi;
			zrzi = zr * zi;
			// escape is checked before the limit
			if ((zr2 >>> 23) + (zi2 >>> 23) > (longint'(4) << 23))
				return ramp_color(count % 16);
			if (count == int'(c.iter_limit))
				return 16'd0;
			zr = wrap_word((zr2 >>> 23) - (zi2 >>> 23) + cr);
			zi = wrap_word(((2 * zrzi) >>> 23) + ci);
		end
		return 16'd0;
	endfunction

	// active high segments with bit 0 as a
	function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// corner in [-2,0) x [-1,1) with small positive steps
	task automatic make_random_cfg(input int limit, output tile_cfg_t c);
		int r;
		r = $random(seed);
		c.x_min = fixed_t'(-(1 << 24) + (r & 32'h00FF_FFFF));
		r = $random(seed);
		c.y_min = fixed_t'(-(1 << 23) + (r & 32'h00FF_FFFF));
		r = $random(seed);
		c.dx = fixed_t'((r & 32'h0000_FFFF) + 32'h0000_1000);
		r = $random(seed);
		c.dy = fixed_t'((r & 32'h0000_FFFF) + 32'h0000_1000);
		c.iter_limit = 10'(limit);
	endtask

	// one tile with every write checked and an optional start pulse mid tile
	task automatic run_tile(input tile_cfg_t c, input int poke_at, input tile_cfg_t poke_cfg);
		int elapsed;
		int writes;
		logic finished;
		elapsed = 0;
		writes = 0;
		finished = 1'b0;
		@(negedge CLOCK_50);
		cfg = c;
		start = 1'b1;
		@(negedge CLOCK_50);
		start = 1'b0;
		while (!finished) begin
			@(negedge CLOCK_50);
			elapsed++;
			start = 1'b0;
			if (elapsed == poke_at) begin
				cfg = poke_cfg;
				start = 1'b1;
			end
			if (wr_valid) begin
				assert (int'(wr.addr) == writes)
				else report_error($sformatf("write address %0d, expected %0d", wr.addr, writes));
				assert (wr.color == expect_color(c, writes))
				else report_error($sformatf("pixel %0d colour %h, expected %h",
					writes, wr.color, expect_color(c, writes)));
				writes++;
			end
			if (done)
				finished = 1'b1;
		end
		assert (writes == tile_pixels)
		else report_error($sformatf("tile gave %0d writes, expected %0d", writes, tile_pixels));
		assert (solve_time == elapsed)
		else report_error($sformatf("solve_time %0d, counted %0d", solve_time, elapsed));
		last_elapsed = elapsed;
	endtask

	// digits and leds against the counted time
	task automatic compare_display();
		logic [31:0] ref_time;
		int k;
		ref_time = last_elapsed;
		for (k = 0; k < 6; k++) begin
			assert (hex_all[7*k +: 7] == ~seg_pattern(ref_time[4*k +: 4]))
			else report_error($sformatf("hex%0d shows %h for counted time %h",
				k, hex_all[7*k +: 7], ref_time));
		end
		assert (ledr == ref_time[31:24])
		else report_error($sformatf("ledr %h, counted time %h", ledr, ref_time));
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic idle_after_reset();
		int k;
		repeat (16) begin
			@(negedge CLOCK_50);
			assert (!wr_valid && !done)
			else report_error("write or done strobe before any start");
		end
		assert (solve_time == 32'd0)
		else report_error($sformatf("solve_time %0d after reset", solve_time));
		for (k = 0; k < 6; k++) begin
			assert (hex_all[7*k +: 7] == ~seg_pattern(4'h0))
			else report_error($sformatf("hex%0d shows %h after reset", k, hex_all[7*k +: 7]));
		end
	endtask

	// c = 0 never escapes
	task automatic interior_tile();
		tile_cfg_t c;
		c = '0;
		c.iter_limit = 10'd15;
		run_tile(c, 0, c);
	endtask

	task automatic random_tiles();
		tile_cfg_t c;
		repeat (2) begin
			make_random_cfg(20, c);
			run_tile(c, 0, c);
		end
	endtask

	// long tile so several digits light up
	task automatic solve_time_readout();
		tile_cfg_t c;
		c = '0;
		c.iter_limit = 10'(max_limit);
		run_tile(c, 0, c);
		compare_display();
		repeat (4) @(negedge CLOCK_50);
		assert (solve_time == last_elapsed)
		else report_error($sformatf("solve_time moved to %0d after done", solve_time));
		compare_display();
	endtask

	task automatic busy_then_restart();
		tile_cfg_t first;
		tile_cfg_t other;
		tile_cfg_t second;
		make_random_cfg(12, first);
		// very different tile that must not be picked up
		other = '0;
		other.x_min = fixed_t'(-(1 << 24));
		other.y_min = fixed_t'(-(1 << 24));
		other.dx = fixed_t'(1 << 20);
		other.dy = fixed_t'(1 << 20);
		other.iter_limit = 10'd3;
		run_tile(first, 300, other);
		make_random_cfg(20, second);
		run_tile(second, 0, second);
	endtask

	initial begin
		reset_key = 1'b1;
		start = 1'b0;
		cfg = '0;
		repeat (8) @(negedge CLOCK_50);
		reset_key = 1'b0;
		idle_after_reset();
		interior_tile();
		random_tiles();
		solve_time_readout();
		busy_then_restart();
		// bound assertions keep their own tally
		if (i_mandel_tile_top.i_mandel_tile_properties.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- verilog/escape_iterator.sv
`timescale 1ns/100ps
`include "mandel_defs.svh"

module escape_iterator (
	input  logic                         CLOCK_50,
	input  logic                         reset_key,
	input  mandel_pkg::pixel_job_t       job,
	input  logic                         job_valid,
	input  logic [`MANDEL_ITER_BITS-1:0] iter_limit,
	output mandel_pkg::escape_result_t   result,
	output logic                         result_valid
);
	import mandel_pkg::*;

	localparam int prod_bits = 2 * `MANDEL_WORD_BITS;
	// 4.0 in the squared domain after the shift
	localparam logic signed [prod_bits-1:0] radius_sq = 4 << `MANDEL_FRAC_BITS;

	logic busy;
	fixed_t zr;
	fixed_t zi;
	fixed_t cr;
	fixed_t ci;
	logic [2*`MANDEL_TILE_BITS-1:0] idx;
	logic [`MANDEL_ITER_BITS-1:0] count;
	logic signed [prod_bits-1:0] zr_sq;
	logic signed [prod_bits-1:0] zi_sq;
	logic signed [prod_bits-1:0] zr_zi;
	logic signed [prod_bits-1:0] mag_sq;
	logic signed [prod_bits-1:0] zr_wide;
	logic signed [prod_bits-1:0] zi_wide;
	logic escaped;
	logic at_limit;
	logic finish;

	//////////////////////////////
	// one z step per cycle
	//////////////////////////////

	// three full-width signed products
	assign zr_sq = zr * zr;
	assign zi_sq = zi * zi;
	assign zr_zi = zr * zi;

	// |z|^2 kept wide, no wrap in the test
	assign mag_sq = (zr_sq >>> `MANDEL_FRAC_BITS) + (zi_sq >>> `MANDEL_FRAC_BITS);
	assign escaped = mag_sq > radius_sq;
	assign at_limit = count == iter_limit;
	assign finish = escaped || at_limit;

	// next z, low word bits kept, so it wraps
	assign zr_wide = (zr_sq >>> `MANDEL_FRAC_BITS) - (zi_sq >>> `MANDEL_FRAC_BITS) + cr;
	// doubling folded into the shift
	assign zi_wide = (zr_zi >>> (`MANDEL_FRAC_BITS - 1)) + ci;

	always_ff @(posedge CLOCK_50) begin
		if (reset_key) begin
			busy <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (job_valid) begin
				busy <= 1'b1;
			end else if (busy && finish) begin
				busy <= 1'b0;
				result_valid <= 1'b1;
			end
		end
	end

	// pixel state, reloaded per job
	always_ff @(posedge CLOCK_50) begin
		if (job_valid) begin
			zr <= '0;
			zi <= '0;
			cr <= job.cr;
			ci <= job.ci;
			idx <= job.idx;
			count <= '0;
		end else if (busy) begin
			if (finish) begin
				// escape wins over limit in the same cycle
				result <= '{idx: idx, iter: count, limit_hit: !escaped};
			end else begin
				zr <= zr_wide[`MANDEL_WORD_BITS-1:0];
				zi <= zi_wide[`MANDEL_WORD_BITS-1:0];
				count <= count + 1'b1;
			end
		end
	end

endmodule

//--- verilog/hex_display.sv
`timescale 1ns/100ps

module hex_display (
	input  logic [23:0] value,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3,
	output logic [6:0]  hex4,
	output logic [6:0]  hex5
);

	// nibble to segments, bit 0 is a
	// patterns active high here, inverted on return
	function automatic logic [6:0] seg_glyph(input logic [3:0] nibble);
		logic [6:0] segs;
		case (nibble)
			4'h0: segs = 7'h3F;
			4'h1: segs = 7'h06;
			4'h2: segs = 7'h5B;
			4'h3: segs = 7'h4F;
			4'h4: segs = 7'h66;
			4'h5: segs = 7'h6D;
			4'h6: segs = 7'h7D;
			4'h7: segs = 7'h07;
			4'h8: segs = 7'h7F;
			4'h9: segs = 7'h6F;
			4'hA: segs = 7'h77;
			// lower case b and d
			4'hB: segs = 7'h7C;
			4'hC: segs = 7'h39;
			4'hD: segs = 7'h5E;
			4'hE: segs = 7'h79;
			default: segs = 7'h71;
		endcase
		return ~segs;
	endfunction

	// hex0 is the lowest nibble
	assign hex0 = seg_glyph(value[3:0]);
	assign hex1 = seg_glyph(value[7:4]);
	assign hex2 = seg_glyph(value[11:8]);
	assign hex3 = seg_glyph(value[15:12]);
	assign hex4 = seg_glyph(value[19:16]);
	assign hex5 = seg_glyph(value[23:20]);

endmodule

//--- verilog/mandel_defs.svh
`ifndef MANDEL_DEFS_SVH
`define MANDEL_DEFS_SVH

//////////////////////////////
// fixed-point format
//////////////////////////////

// signed Q3.23, 27 bits total
// range is roughly -8.0 to +8.0
`define MANDEL_FRAC_BITS 23
`define MANDEL_WORD_BITS 27

//////////////////////////////
// tile geometry and limits
//////////////////////////////

// 5 bits per axis, 32 x 32 pixel tile
`define MANDEL_TILE_BITS 5

// iteration counter and iteration limit width
`define MANDEL_ITER_BITS 10

// RGB565 pixel word
`define MANDEL_COLOR_BITS 16

`endif

//--- verilog/mandel_pkg.sv
`include "mandel_defs.svh"

package mandel_pkg;

	// signed fixed-point number
	typedef logic signed [`MANDEL_WORD_BITS-1:0] fixed_t;

	// tile setup, captured on start
	typedef struct packed {
		fixed_t x_min;
		fixed_t y_min;
		fixed_t dx;
		fixed_t dy;
		logic [`MANDEL_ITER_BITS-1:0] iter_limit;
	} tile_cfg_t;

	// one pixel to iterate, idx is row * 32 + col
	typedef struct packed {
		logic [2*`MANDEL_TILE_BITS-1:0] idx;
		fixed_t cr;
		fixed_t ci;
	} pixel_job_t;

	// escape count of one pixel
	typedef struct packed {
		logic [2*`MANDEL_TILE_BITS-1:0] idx;
		logic [`MANDEL_ITER_BITS-1:0] iter;
		logic limit_hit;
	} escape_result_t;

	// one pixel write, address equals pixel index
	typedef struct packed {
		logic [2*`MANDEL_TILE_BITS-1:0] addr;
		logic [`MANDEL_COLOR_BITS-1:0] color;
	} write_rec_t;

	// green ramp up, then blue, then green back down
	// red field always zero
	function automatic logic [`MANDEL_COLOR_BITS-1:0] palette_color(input logic [3:0] level);
		logic [5:0] green;
		logic [4:0] blue;
		if (level <= 4'd6) begin
			green = {level[2:0], 3'b000};
			blue = 5'd0;
		end else if (level == 4'd7) begin
			green = 6'd56;
			blue = 5'd8;
		end else if (level == 4'd8) begin
			green = 6'd56;
			blue = 5'd16;
		end else begin
			// 15 - level is 0..6 here
			green = {3'(4'd15 - level), 3'b000};
			blue = 5'd24;
		end
		return {5'd0, green, blue};
	endfunction

endpackage

//--- verilog/mandel_tile_top.sv
`timescale 1ns/100ps
`include "mandel_defs.svh"

module mandel_tile_top (
	input  logic                   CLOCK_50,
	input  logic                   reset_key,
	input  mandel_pkg::tile_cfg_t  cfg,
	input  logic                   start,
	output mandel_pkg::write_rec_t wr,
	output logic                   wr_valid,
	output logic                   done,
	output logic [31:0]            solve_time,
	output logic [6:0]             hex0,
	output logic [6:0]             hex1,
	output logic [6:0]             hex2,
	output logic [6:0]             hex3,
	output logic [6:0]             hex4,
	output logic [6:0]             hex5,
	output logic [7:0]             ledr
);
	import mandel_pkg::*;

	pixel_job_t job;
	logic job_valid;
	logic [`MANDEL_ITER_BITS-1:0] iter_limit;
	escape_result_t result;
	logic result_valid;

	//////////////////////////////
	// solver chain
	//////////////////////////////

	tile_control i_tile_control (
		.CLOCK_50     (CLOCK_50),
		.reset_key    (reset_key),
		.cfg          (cfg),
		.start        (start),
		.result_valid (result_valid),
		.job          (job),
		.job_valid    (job_valid),
		.iter_limit   (iter_limit),
		.done         (done),
		.solve_time   (solve_time)
	);

	escape_iterator i_escape_iterator (
		.CLOCK_50     (CLOCK_50),
		.reset_key    (reset_key),
		.job          (job),
		.job_valid    (job_valid),
		.iter_limit   (iter_limit),
		.result       (result),
		.result_valid (result_valid)
	);

	// write port, no back-pressure
	palette_map i_palette_map (
		.CLOCK_50     (CLOCK_50),
		.reset_key    (reset_key),
		.result       (result),
		.result_valid (result_valid),
		.wr           (wr),
		.wr_valid     (wr_valid)
	);

	//////////////////////////////
	// solve time readout
	//////////////////////////////

	// low 24 bits on the digits
	hex_display i_hex_display (
		.value (solve_time[23:0]),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3),
		.hex4  (hex4),
		.hex5  (hex5)
	);

	// top byte on the leds
	assign ledr = solve_time[31:24];

endmodule

//--- verilog/palette_map.sv
`timescale 1ns/100ps

module palette_map (
	input  logic                       CLOCK_50,
	input  logic                       reset_key,
	input  mandel_pkg::escape_result_t result,
	input  logic                       result_valid,
	output mandel_pkg::write_rec_t     wr,
	output logic                       wr_valid
);
	import mandel_pkg::*;

	//////////////////////////////
	// result -> write record
	//////////////////////////////

	// strobe trails result by one cycle
	always_ff @(posedge CLOCK_50) begin
		if (reset_key)
			wr_valid <= 1'b0;
		else
			wr_valid <= result_valid;
	end

	// address is pixel index
	// interior pixels black, others by low 4 bits of count
	always_ff @(posedge CLOCK_50) begin
		if (result_valid) begin
			wr.addr <= result.idx;
			if (result.limit_hit)
				wr.color <= '0;
			else
				wr.color <= palette_color(result.iter[3:0]);
		end
	end

endmodule

//--- verilog/tile_control.sv
`timescale 1ns/100ps
`include "mandel_defs.svh"

module tile_control (
	input  logic                         CLOCK_50,
	input  logic                         reset_key,
	input  mandel_pkg::tile_cfg_t        cfg,
	input  logic                         start,
	input  logic                         result_valid,
	output mandel_pkg::pixel_job_t       job,
	output logic                         job_valid,
	output logic [`MANDEL_ITER_BITS-1:0] iter_limit,
	output logic                         done,
	output logic [31:0]                  solve_time
);
	import mandel_pkg::*;

	tile_cfg_t cfg_q;
	logic busy;
	logic [`MANDEL_TILE_BITS-1:0] row;
	logic [`MANDEL_TILE_BITS-1:0] col;
	fixed_t cr_acc;
	fixed_t ci_acc;
	logic accept;
	logic last_col;
	logic last_pixel;

	// start only counts when idle
	assign accept = start && !busy;
	assign last_col = &col;
	assign last_pixel = last_col && (&row);

	//////////////////////////////
	// sequencing and timer
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset_key) begin
			busy <= 1'b0;
			row <= '0;
			col <= '0;
			job_valid <= 1'b0;
			done <= 1'b0;
			solve_time <= 32'd0;
		end else begin
			// strobes default low
			job_valid <= 1'b0;
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				row <= '0;
				col <= '0;
				// pixel 0 goes out next cycle
				job_valid <= 1'b1;
				solve_time <= 32'd0;
			end else if (busy) begin
				// one tick per edge while solving
				solve_time <= solve_time + 32'd1;
				if (result_valid) begin
					if (last_pixel) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						job_valid <= 1'b1;
						// col wraps 31 -> 0 on its own
						col <= col + 1'b1;
						if (last_col)
							row <= row + 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////
	// coordinate accumulators
	//////////////////////////////

	// step by dx / dy instead of multiplying
	always_ff @(posedge CLOCK_50) begin
		if (accept) begin
			cfg_q <= cfg;
			cr_acc <= cfg.x_min;
			ci_acc <= cfg.y_min;
		end else if (busy && result_valid && !last_pixel) begin
			if (last_col) begin
				// new row, back to left edge
				cr_acc <= cfg_q.x_min;
				ci_acc <= ci_acc + cfg_q.dy;
			end else begin
				cr_acc <= cr_acc + cfg_q.dx;
			end
		end
	end

	assign job = '{idx: {row, col}, cr: cr_acc, ci: ci_acc};
	assign iter_limit = cfg_q.iter_limit;

endmodule

//--- vlog.f
+incdir+verilog
verilog/mandel_pkg.sv
verilog/tile_control.sv
verilog/escape_iterator.sv
verilog/palette_map.sv
verilog/hex_display.sv
verilog/mandel_tile_top.sv
tb/mandel_tile_properties.sv
tb/mandel_tile_tb.sv
